// ==== compile.f ====
mbus_pkg.sv
work_ram.sv
mbus_decode.sv
mbus_execute.sv
mbus_result.sv
mbus_top.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 -f compile.f --top-module tb_top -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing -f compile.f --top-module tb_top

clean:
	rm -rf obj_dir sim.log

// ==== tb_top.sv ====
module tb_top import mbus_pkg::*; ;

	// Upper bound on requests issued for the watchdog
	localparam int REQ_COUNT = 620;

	logic                   MCLK;
	logic                   reset;
	logic                   req_valid;
	logic                   req_ready;
	logic [ADDR_W-1:0]      req_addr;
	logic                   req_write;
	logic [DATA_W-1:0]      req_wdata;
	logic [BE_W-1:0]        req_be;
	logic                   resp_valid;
	logic                   resp_ready;
	logic [DATA_W-1:0]      resp_data;
	logic [BYTE_ADDR_W-1:0] rom_size;
	logic [ADDR_W-1:0]      rom_addr;
	logic [BE_W-1:0]        rom_be;
	logic                   rom_req;
	logic                   rom_ack;
	logic [DATA_W-1:0]      rom_data;
	logic                   z80_busreq_n;
	logic                   z80_reset_n;
	int                     test_id;
	int                     error_count;
	int                     check_count;
	int                     pending;
	logic [31:0]            lfsr;
	int                     rom_delay;
	logic                   rom_busy;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	initial begin
		MCLK = 1'b0;
		forever #10 MCLK = ~MCLK;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge MCLK);
		reset <= 1'b0;
	end

	// ----------------------------------------------------------
	// ROM responder
	// ----------------------------------------------------------
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack <= 1'b0;
			rom_busy = 1'b0;
			rom_delay = 0;
		end else if (rom_req != rom_ack) begin
			if (!rom_busy) begin
				rom_delay = int'(rand_bits(3)) % 6;
				rom_busy = 1'b1;
			end
			if (rom_delay == 0) begin
				rom_data <= rom_addr[15:0] ^ 16'hA5A5;
				rom_ack <= rom_req;
				rom_busy = 1'b0;
			end else begin
				rom_delay--;
			end
		end
	end

	// Random back-pressure on the response side
	always @(posedge MCLK) begin
		if (reset)
			resp_ready <= 1'b0;
		else
			resp_ready <= (rand_bits(2) != 0);
	end

	initial begin
		#((REQ_COUNT * 40 + 200) * 20);
		$display("Watchdog expired before all requests were answered");
		$display("Test failures found");
		$finish;
	end

	task automatic send_request(input logic [23:0] b, input logic wr,
			input logic [15:0] wd, input logic [1:0] be);
		req_valid <= 1'b1;
		req_addr <= b[23:1];
		req_write <= wr;
		req_wdata <= wd;
		req_be <= be;
		do @(posedge MCLK); while (!req_ready);
		// Occasional idle cycle between requests
		if (rand_bits(2) == 0) begin
			req_valid <= 1'b0;
			@(posedge MCLK);
		end
	endtask

	task automatic read_word(input logic [23:0] b);
		send_request(b, 1'b0, 16'h0000, 2'b11);
	endtask

	task automatic write_word(input logic [23:0] b, input logic [15:0] wd,
			input logic [1:0] be);
		send_request(b, 1'b1, wd, be);
	endtask

	task automatic drain_pipeline();
		req_valid <= 1'b0;
		do @(posedge MCLK); while (pending != 0);
		@(posedge MCLK);
	endtask

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	initial begin
		logic [31:0] r;
		logic [2:0]  kind;
		logic        wr;
		logic [15:0] wd;
		logic [1:0]  be;
		logic [23:0] b;

		lfsr = 32'h6faf_b488;
		req_valid = 1'b0;
		req_addr = '0;
		req_write = 1'b0;
		req_wdata = '0;
		req_be = '0;
		resp_ready = 1'b0;
		rom_size = 24'h100000;
		rom_ack = 1'b0;
		rom_data = '0;
		test_id = 0;
		repeat (4) @(posedge MCLK);

		// Open bus straight after reset
		test_id <= 5;
		read_word(24'h800000);
		read_word(24'hA13000);
		read_word(24'hA11100);

		test_id <= 1;
		for (int i = 0; i < 8; i++)
			write_word(24'hE00000 + 24'(i * 2), 16'h1111 * 16'(i + 1), 2'b11);
		write_word(24'hE00002, 16'hAB00, 2'b10);
		write_word(24'hE00004, 16'h00CD, 2'b01);
		write_word(24'hE00006, 16'hFFFF, 2'b00);
		for (int i = 0; i < 8; i++)
			read_word(24'hE00000 + 24'(i * 2));
		// Mirrors of the same words
		read_word(24'hF00002);
		read_word(24'hFF0004);
		read_word(24'hE80006);

		test_id <= 5;
		read_word(24'hC00000);

		test_id <= 2;
		read_word(24'h000100);
		read_word(24'h0FFFFE);
		read_word(24'h100000);
		read_word(24'h3FFFFE);
		read_word(24'h800010);

		// Small cart ignores bank writes
		test_id <= 3;
		write_word(24'hA130F2, 16'h0003, 2'b11);
		read_word(24'h080000);
		drain_pipeline();
		rom_size <= 24'h400000;
		@(posedge MCLK);
		write_word(24'hA130F2, 16'h000A, 2'b11);
		write_word(24'hA130FE, 16'h001F, 2'b11);
		read_word(24'h080000);
		read_word(24'h380002);
		read_word(24'h000100);
		read_word(24'hA130F2);

		test_id <= 4;
		write_word(24'hA11100, 16'h0100, 2'b11);
		read_word(24'hA11100);
		write_word(24'hA11200, 16'h0100, 2'b11);
		read_word(24'hA11200);
		write_word(24'hA11100, 16'h0000, 2'b01);
		read_word(24'hA11100);
		write_word(24'hA11100, 16'h0000, 2'b10);
		read_word(24'hA11100);
		drain_pipeline();

		test_id <= 6;
		rom_size <= 24'h300000;
		@(posedge MCLK);
		for (int i = 0; i < 64; i++)
			write_word(24'hE00000 + 24'(i * 2), 16'(rand_bits(16)), 2'b11);
		for (int n = 0; n < 400; n++) begin
			kind = 3'(rand_bits(3));
			wr = 1'(rand_bits(1));
			wd = 16'(rand_bits(16));
			be = 2'(rand_bits(2));
			if (be == 2'b00)
				be = 2'b11;
			case (kind)
				3'd0, 3'd1: begin
					r = rand_bits(11);
					b = {3'b111, r[10:6], 9'd0, r[5:0], 1'b0};
				end
				3'd2, 3'd3: begin
					r = rand_bits(21);
					b = {2'b00, r[20:0], 1'b0};
				end
				3'd4: begin
					r = rand_bits(1);
					b = {12'hA11, r[0] ? 4'd1 : 4'd2, 8'h00};
				end
				3'd5: begin
					r = rand_bits(3);
					b = {16'hA130, 4'hF, r[2:0], 1'b0};
				end
				default: begin
					r = rand_bits(19);
					b = {4'h8, r[18:0], 1'b0};
				end
			endcase
			send_request(b, wr, wd, be);
		end
		drain_pipeline();

		$display("Checks: %0d  errors: %0d  unanswered: %0d",
			check_count, error_count, pending);
		if (error_count == 0 && pending == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	mbus_top dut0 (
		.MCLK         (MCLK),
		.reset        (reset),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_addr     (req_addr),
		.req_write    (req_write),
		.req_wdata    (req_wdata),
		.req_be       (req_be),
		.resp_valid   (resp_valid),
		.resp_ready   (resp_ready),
		.resp_data    (resp_data),
		.rom_size     (rom_size),
		.rom_addr     (rom_addr),
		.rom_be       (rom_be),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.rom_data     (rom_data),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	tb_checker chk0 (
		.MCLK         (MCLK),
		.reset        (reset),
		.test_id      (test_id),
		.rom_size     (rom_size),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_addr     (req_addr),
		.req_write    (req_write),
		.req_wdata    (req_wdata),
		.req_be       (req_be),
		.resp_valid   (resp_valid),
		.resp_ready   (resp_ready),
		.resp_data    (resp_data),
		.rom_req      (rom_req),
		.rom_addr     (rom_addr),
		.rom_be       (rom_be),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n),
		.error_count  (error_count),
		.check_count  (check_count),
		.pending      (pending)
	);

endmodule

// ==== tb_checker.sv ====
module tb_checker import mbus_pkg::*; (
	input  logic                   MCLK,
	input  logic                   reset,
	input  int                     test_id,
	input  logic [BYTE_ADDR_W-1:0] rom_size,
	input  logic                   req_valid,
	input  logic                   req_ready,
	input  logic [ADDR_W-1:0]      req_addr,
	input  logic                   req_write,
	input  logic [DATA_W-1:0]      req_wdata,
	input  logic [BE_W-1:0]        req_be,
	input  logic                   resp_valid,
	input  logic                   resp_ready,
	input  logic [DATA_W-1:0]      resp_data,
	input  logic                   rom_req,
	input  logic [ADDR_W-1:0]      rom_addr,
	input  logic [BE_W-1:0]        rom_be,
	input  logic                   z80_busreq_n,
	input  logic                   z80_reset_n,
	output int                     error_count,
	output int                     check_count,
	output int                     pending
);

	logic [15:0] ram_model [2**RAM_AW];
	logic [4:0]  bank_model [8];
	logic        bank_on;
	logic        busreq_n_model;
	logic        reset_n_model;
	logic [15:0] ob_model;
	logic [15:0] exp_q [$];
	int          id_q [$];
	logic [22:0] rom_q [$];
	logic [1:0]  rom_be_q [$];
	logic        rom_req_seen;
	int          errors;
	int          checks;

	function automatic string test_label(input int id);
		case (id)
			1: return "ram_rw";
			2: return "rom_read";
			3: return "bank_map";
			4: return "z80_ctrl";
			5: return "open_bus";
			6: return "random_mix";
			default: return "none";
		endcase
	endfunction

	// Expected read data of one request with its side effects applied
	function automatic logic [15:0] predict_response(input logic [22:0] wa, input logic wr,
			input logic [15:0] wd, input logic [1:0] be);
		logic [23:0] b;
		logic [22:0] ra;
		logic [3:0]  pg;
		logic [15:0] d;
		logic        sel;
		b = {wa, 1'b0};
		pg = b[11:8];
		d = 16'h0000;
		if (b < 24'h400000) begin
			if (!wr && b < rom_size) begin
				ra = bank_on ? {bank_model[wa[20:18]], wa[17:0]} : wa;
				rom_q.push_back(ra);
				rom_be_q.push_back(be);
				d = ra[15:0] ^ 16'hA5A5;
				ob_model = d;
			end
		end else if (b[23:12] == 12'hA11 && b[7:0] == 8'h00 && (pg == 4'd1 || pg == 4'd2)) begin
			if (wr) begin
				if (be[1] && pg == 4'd1)
					busreq_n_model = ~wd[8];
				if (be[1] && pg == 4'd2)
					reset_n_model = wd[8];
			end else begin
				sel = (pg == 4'd1) ? busreq_n_model : reset_n_model;
				d = {ob_model[15:9], sel, ob_model[7:0]};
			end
		end else if (b[23:8] == 16'hA130) begin
			if (wr && rom_size > 24'h200000 && wa[2:0] != 3'd0) begin
				bank_model[wa[2:0]] = wd[4:0];
				bank_on = 1'b1;
			end else if (!wr) begin
				d = ob_model;
			end
		end else if (b[23:21] == 3'b111) begin
			if (wr) begin
				if (be[0])
					ram_model[wa[14:0]][7:0] = wd[7:0];
				if (be[1])
					ram_model[wa[14:0]][15:8] = wd[15:8];
			end else begin
				d = ram_model[wa[14:0]];
				ob_model = d;
			end
		end else if (!wr) begin
			d = ob_model;
		end
		return d;
	endfunction

	// ----------------------------------------------------------
	// Scoreboard
	// ----------------------------------------------------------
	always @(posedge MCLK) begin
		logic [15:0] exp;
		logic [22:0] exp_rom;
		logic [1:0]  exp_be;
		int          id;
		if (reset) begin
			for (int i = 0; i < 8; i++)
				bank_model[i] = 5'(i);
			bank_on = 1'b0;
			busreq_n_model = 1'b1;
			reset_n_model = 1'b0;
			ob_model = 16'h4E71;
			exp_q.delete();
			id_q.delete();
			rom_q.delete();
			rom_be_q.delete();
			rom_req_seen = 1'b0;
		end else begin
			if (resp_valid && resp_ready) begin
				if (exp_q.size() == 0) begin
					$display("Response arrived with no request outstanding");
					errors++;
				end else begin
					exp = exp_q.pop_front();
					id = id_q.pop_front();
					checks++;
					if (resp_data !== exp) begin
						$display("Mismatch %s: expected %h, actual %h",
							test_label(id), exp, resp_data);
						errors++;
					end
				end
			end
			// Mapped address and byte enables of each new ROM fetch
			if (rom_req !== rom_req_seen) begin
				rom_req_seen = rom_req;
				if (rom_q.size() == 0) begin
					$display("ROM fetch started with no ROM read outstanding");
					errors++;
				end else begin
					exp_rom = rom_q.pop_front();
					exp_be = rom_be_q.pop_front();
					checks++;
					if (rom_addr !== exp_rom) begin
						$display("Mismatch %s rom_addr: expected %h, actual %h",
							test_label(test_id), exp_rom, rom_addr);
						errors++;
					end
					if (rom_be !== exp_be) begin
						$display("Mismatch %s rom_be: expected %b, actual %b",
							test_label(test_id), exp_be, rom_be);
						errors++;
					end
				end
			end
			// Z80 lines only settle once nothing is in flight
			if (exp_q.size() == 0) begin
				if (z80_busreq_n !== busreq_n_model || z80_reset_n !== reset_n_model) begin
					$display("Mismatch %s z80 lines: expected %b%b, actual %b%b",
						test_label(test_id), busreq_n_model, reset_n_model,
						z80_busreq_n, z80_reset_n);
					errors++;
				end
			end
			if (req_valid && req_ready) begin
				exp_q.push_back(predict_response(req_addr, req_write, req_wdata, req_be));
				id_q.push_back(test_id);
			end
		end
		error_count <= errors;
		check_count <= checks;
		pending <= exp_q.size();
	end

	initial begin
		errors = 0;
		checks = 0;
		error_count = 0;
		check_count = 0;
		pending = 0;
	end

endmodule

// ==== mbus_top.sv ====
module mbus_top import mbus_pkg::*; (
	input  logic                   MCLK,
	input  logic                   reset,

	input  logic                   req_valid,
	output logic                   req_ready,
	input  logic [ADDR_W-1:0]      req_addr,
	input  logic                   req_write,
	input  logic [DATA_W-1:0]      req_wdata,
	input  logic [BE_W-1:0]        req_be,

	output logic                   resp_valid,
	input  logic                   resp_ready,
	output logic [DATA_W-1:0]      resp_data,

	input  logic [BYTE_ADDR_W-1:0] rom_size,
	output logic [ADDR_W-1:0]      rom_addr,
	output logic [BE_W-1:0]        rom_be,
	output logic                   rom_req,
	input  logic                   rom_ack,
	input  logic [DATA_W-1:0]      rom_data,

	output logic                   z80_busreq_n,
	output logic                   z80_reset_n
);

	// Decode to execute
	logic              dec_valid;
	mbus_target_t      dec_target;
	logic [ADDR_W-1:0] dec_addr;
	logic              dec_write;
	logic [DATA_W-1:0] dec_wdata;
	logic [BE_W-1:0]   dec_be;
	logic              dec_ready;

	// Execute to result
	logic              exe_valid;
	logic [DATA_W-1:0] exe_data;
	logic              exe_from_mem;
	logic              exe_ready;
	logic [DATA_W-1:0] open_bus;

	mbus_decode decode0 (
		.MCLK       (MCLK),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_addr   (req_addr),
		.req_write  (req_write),
		.req_wdata  (req_wdata),
		.req_be     (req_be),
		.rom_size   (rom_size),
		.dec_valid  (dec_valid),
		.dec_target (dec_target),
		.dec_addr   (dec_addr),
		.dec_write  (dec_write),
		.dec_wdata  (dec_wdata),
		.dec_be     (dec_be),
		.dec_ready  (dec_ready)
	);

	mbus_execute execute0 (
		.MCLK         (MCLK),
		.reset        (reset),
		.dec_valid    (dec_valid),
		.dec_target   (dec_target),
		.dec_addr     (dec_addr),
		.dec_write    (dec_write),
		.dec_wdata    (dec_wdata),
		.dec_be       (dec_be),
		.dec_ready    (dec_ready),
		.rom_size     (rom_size),
		.open_bus     (open_bus),
		.rom_addr     (rom_addr),
		.rom_be       (rom_be),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.rom_data     (rom_data),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n),
		.exe_valid    (exe_valid),
		.exe_data     (exe_data),
		.exe_from_mem (exe_from_mem),
		.exe_ready    (exe_ready)
	);

	mbus_result result0 (
		.MCLK         (MCLK),
		.reset        (reset),
		.exe_valid    (exe_valid),
		.exe_data     (exe_data),
		.exe_from_mem (exe_from_mem),
		.exe_ready    (exe_ready),
		.open_bus     (open_bus),
		.resp_valid   (resp_valid),
		.resp_data    (resp_data),
		.resp_ready   (resp_ready)
	);

endmodule

// ==== mbus_result.sv ====
module mbus_result import mbus_pkg::*; (
	input  logic              MCLK,
	input  logic              reset,

	input  logic              exe_valid,
	input  logic [DATA_W-1:0] exe_data,
	input  logic              exe_from_mem,
	output logic              exe_ready,

	output logic [DATA_W-1:0] open_bus,

	output logic              resp_valid,
	output logic [DATA_W-1:0] resp_data,
	input  logic              resp_ready
);

	logic exe_fire;

	assign exe_ready = !resp_valid || resp_ready;
	assign exe_fire = exe_valid && exe_ready;

	always_ff @(posedge MCLK) begin
		if (reset)
			resp_valid <= 1'b0;
		else if (exe_fire)
			resp_valid <= 1'b1;
		else if (resp_ready)
			resp_valid <= 1'b0;
	end

	always_ff @(posedge MCLK) begin
		if (exe_fire)
			resp_data <= exe_data;
	end

	// Last word seen on the data bus from ROM or RAM
	always_ff @(posedge MCLK) begin
		if (reset)
			open_bus <= OPEN_BUS_INIT;
		else if (exe_fire && exe_from_mem)
			open_bus <= exe_data;
	end

endmodule

// ==== mbus_execute.sv ====
module mbus_execute import mbus_pkg::*; (
	input  logic                   MCLK,
	input  logic                   reset,

	input  logic                   dec_valid,
	input  mbus_target_t           dec_target,
	input  logic [ADDR_W-1:0]      dec_addr,
	input  logic                   dec_write,
	input  logic [DATA_W-1:0]      dec_wdata,
	input  logic [BE_W-1:0]        dec_be,
	output logic                   dec_ready,

	input  logic [BYTE_ADDR_W-1:0] rom_size,
	input  logic [DATA_W-1:0]      open_bus,

	output logic [ADDR_W-1:0]      rom_addr,
	output logic [BE_W-1:0]        rom_be,
	output logic                   rom_req,
	input  logic                   rom_ack,
	input  logic [DATA_W-1:0]      rom_data,

	output logic                   z80_busreq_n,
	output logic                   z80_reset_n,

	output logic                   exe_valid,
	output logic [DATA_W-1:0]      exe_data,
	output logic                   exe_from_mem,
	input  logic                   exe_ready
);

	mbus_state_t            state;
	logic [BANK_W-1:0]      bank [BANK_N];
	logic                   bank_mode;
	logic                   dec_fire;
	logic                   rom_done;
	logic [BYTE_ADDR_W-1:0] byte_addr;
	logic [3:0]             page;
	logic [DATA_W-1:0]      ob_now;
	logic [DATA_W-1:0]      imm_data;
	logic                   ctrl_bit;
	logic [ADDR_W-1:0]      mapped_addr;
	logic                   ram_we;
	logic [DATA_W-1:0]      ram_rdata;

	// st_done means the output slot is full
	assign exe_valid = (state == st_done);
	assign dec_ready = (state == st_idle) || (state == st_done && exe_ready);
	assign dec_fire = dec_valid && dec_ready;
	assign rom_done = (state == st_rom_wait) && (rom_ack == rom_req);

	assign byte_addr = {dec_addr, 1'b0};
	assign page = dec_addr[10:7];

	// A memory read still in the slot is newer than the result stage copy
	assign ob_now = (state == st_done && exe_from_mem) ? exe_data : open_bus;

	// 512 KB windows picked by A21:19
	assign mapped_addr = bank_mode ? {bank[dec_addr[20:18]], dec_addr[17:0]} : dec_addr;

	assign ram_we = dec_fire && dec_write && dec_target == tgt_ram;

	// Data for accesses that finish without waiting
	always_comb begin
		ctrl_bit = (page == CTRL_BUSREQ_PAGE) ? z80_busreq_n : z80_reset_n;
		if (dec_write) begin
			imm_data = '0;
		end else begin
			case (dec_target)
				tgt_ctrl: imm_data = {ob_now[15:9], ctrl_bit, ob_now[7:0]};
				// Empty cart space reads zero
				tgt_none: imm_data = (byte_addr < ROM_LIMIT) ? '0 : ob_now;
				default:  imm_data = ob_now;
			endcase
		end
	end

	// ----------------------------------------------------------
	// Access FSM
	// ----------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= st_idle;
			rom_req <= 1'b0;
		end else begin
			case (state)
				st_rom_wait: begin
					if (rom_done)
						state <= st_done;
				end
				st_ram_read: state <= st_done;
				default: begin
					if (dec_fire) begin
						if (!dec_write && dec_target == tgt_rom) begin
							rom_req <= ~rom_req;
							state <= st_rom_wait;
						end else if (!dec_write && dec_target == tgt_ram) begin
							state <= st_ram_read;
						end else begin
							state <= st_done;
						end
					end else if (state == st_done && exe_ready) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge MCLK) begin
		if (dec_fire) begin
			exe_data <= imm_data;
			exe_from_mem <= 1'b0;
		end
		if (dec_fire && !dec_write && dec_target == tgt_rom) begin
			rom_addr <= mapped_addr;
			rom_be <= dec_be;
		end
		if (rom_done) begin
			exe_data <= rom_data;
			exe_from_mem <= 1'b1;
		end
		if (state == st_ram_read) begin
			exe_data <= ram_rdata;
			exe_from_mem <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Bank and Z80 control registers
	// ----------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_mode <= 1'b0;
			for (int i = 0; i < BANK_N; i++)
				bank[i] <= BANK_W'(i);
			z80_busreq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (dec_fire && dec_write) begin
			// Slot 0 stays fixed, as on SSF2 carts
			if (dec_target == tgt_bank && rom_size > ROM_BANKED_MIN &&
				dec_addr[2:0] != 3'd0) begin
				bank[dec_addr[2:0]] <= dec_wdata[BANK_W-1:0];
				bank_mode <= 1'b1;
			end
			if (dec_target == tgt_ctrl && dec_be[1]) begin
				if (page == CTRL_BUSREQ_PAGE)
					z80_busreq_n <= ~dec_wdata[8];
				if (page == CTRL_RESET_PAGE)
					z80_reset_n <= dec_wdata[8];
			end
		end
	end

	work_ram ram0 (
		.MCLK  (MCLK),
		.addr  (dec_addr[RAM_AW-1:0]),
		.wdata (dec_wdata),
		.we    (ram_we),
		.be    (dec_be),
		.rdata (ram_rdata)
	);

endmodule

// ==== mbus_decode.sv ====
module mbus_decode import mbus_pkg::*; (
	input  logic                   MCLK,
	input  logic                   reset,

	input  logic                   req_valid,
	output logic                   req_ready,
	input  logic [ADDR_W-1:0]      req_addr,
	input  logic                   req_write,
	input  logic [DATA_W-1:0]      req_wdata,
	input  logic [BE_W-1:0]        req_be,

	input  logic [BYTE_ADDR_W-1:0] rom_size,

	output logic                   dec_valid,
	output mbus_target_t           dec_target,
	output logic [ADDR_W-1:0]      dec_addr,
	output logic                   dec_write,
	output logic [DATA_W-1:0]      dec_wdata,
	output logic [BE_W-1:0]        dec_be,
	input  logic                   dec_ready
);

	logic [BYTE_ADDR_W-1:0] byte_addr;
	logic [3:0]             page;
	mbus_target_t           target;

	assign byte_addr = {req_addr, 1'b0};
	assign page = byte_addr[11:8];

	// Take a new request when empty or draining this cycle
	assign req_ready = !dec_valid || dec_ready;

	// ----------------------------------------------------------
	// Address map
	// ----------------------------------------------------------
	always_comb begin
		target = tgt_none;
		if (byte_addr < ROM_LIMIT) begin
			// Past the end of the cart reads as nothing
			if (byte_addr < rom_size)
				target = tgt_rom;
		end else if (byte_addr[23:12] == CTRL_HI && byte_addr[7:1] == 7'd0) begin
			if (page == CTRL_BUSREQ_PAGE || page == CTRL_RESET_PAGE)
				target = tgt_ctrl;
		end else if (byte_addr[23:8] == BANK_HI) begin
			target = tgt_bank;
		end else if (byte_addr[23:21] == RAM_HI) begin
			target = tgt_ram;
		end
	end

	always_ff @(posedge MCLK) begin
		if (reset)
			dec_valid <= 1'b0;
		else if (req_ready)
			dec_valid <= req_valid;
	end

	always_ff @(posedge MCLK) begin
		if (req_valid && req_ready) begin
			dec_target <= target;
			dec_addr <= req_addr;
			dec_write <= req_write;
			dec_wdata <= req_wdata;
			dec_be <= req_be;
		end
	end

endmodule

// ==== work_ram.sv ====
module work_ram import mbus_pkg::*; (
	input  logic              MCLK,
	input  logic [RAM_AW-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	input  logic              we,
	input  logic [BE_W-1:0]   be,
	output logic [DATA_W-1:0] rdata
);

	logic [DATA_W-1:0] mem [2**RAM_AW];

	// One lane per byte enable
	always_ff @(posedge MCLK) begin
		if (we) begin
			for (int i = 0; i < BE_W; i++) begin
				if (be[i])
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
	end

	// Registered read port
	always_ff @(posedge MCLK) begin
		rdata <= mem[addr];
	end

endmodule

// ==== mbus_pkg.sv ====
package mbus_pkg;

	// ----------------------------------------------------------
	// Bus widths
	// ----------------------------------------------------------

	// Word address, byte address bits 23:1
	localparam int ADDR_W = 23;
	localparam int BYTE_ADDR_W = ADDR_W + 1;
	localparam int DATA_W = 16;
	localparam int BE_W = DATA_W / 8;

	// 64 KB work RAM as 32K words
	localparam int RAM_AW = 15;

	// SSF2 style bank registers
	localparam int BANK_W = 5;
	localparam int BANK_N = 8;

	// ----------------------------------------------------------
	// Address map
	// ----------------------------------------------------------

	// ROM area ends at 4 MB
	localparam logic [BYTE_ADDR_W-1:0] ROM_LIMIT = 24'h400000;

	// Banking only for carts larger than 2 MB
	localparam logic [BYTE_ADDR_W-1:0] ROM_BANKED_MIN = 24'h200000;

	// Control registers live at A11x00
	localparam logic [11:0] CTRL_HI = 12'hA11;
	localparam logic [3:0] CTRL_BUSREQ_PAGE = 4'd1;
	localparam logic [3:0] CTRL_RESET_PAGE = 4'd2;

	// Bank registers at A130xx
	localparam logic [15:0] BANK_HI = 16'hA130;

	// Work RAM is the top eighth, E00000-FFFFFF
	localparam logic [2:0] RAM_HI = 3'b111;

	// NOP opcode, what the bus floats to after reset
	localparam logic [DATA_W-1:0] OPEN_BUS_INIT = 16'h4E71;

	// ----------------------------------------------------------
	// Types
	// ----------------------------------------------------------

	typedef enum logic [2:0] {
		tgt_rom,
		tgt_ram,
		tgt_ctrl,
		tgt_bank,
		tgt_none
	} mbus_target_t;

	typedef enum logic [1:0] {
		st_idle,
		st_rom_wait,
		st_ram_read,
		st_done
	} mbus_state_t;

endpackage
